// File: hw/core_cfg_pkg.sv
package core_cfg_pkg;

    // datapath word
    localparam int DATA_W = 32;

    // architectural register file
    localparam int REG_COUNT = 32;
    localparam int REG_W = 5;

    // micro-op tag, supplied with each micro-op
    localparam int TAG_W = 4;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [REG_W-1:0] reg_idx_t;
    typedef logic [TAG_W-1:0] tag_t;

endpackage

// File: hw/uop_pkg.sv
package uop_pkg;

    import core_cfg_pkg::*;

    // immediate is a full data word
    localparam int IMM_W = DATA_W;
    localparam int OP_W = 3;

    typedef enum logic [OP_W-1:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5,
        OP_LUI  = 3'd6
    } opcode_e;

    typedef logic [IMM_W-1:0] imm_t;

    // second operand comes from the immediate
    function automatic logic op_uses_imm(opcode_e op);
        logic uses_imm;
        case (op)
            OP_ADDI,
            OP_LUI: uses_imm = 1'b1;
            default: uses_imm = 1'b0;
        endcase
        return uses_imm;
    endfunction

endpackage

// File: hw/tagged_regfile.sv
`timescale 1ns/1ns

module tagged_regfile import core_cfg_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,

    input  reg_idx_t rd_addr1_i,
    input  reg_idx_t rd_addr2_i,
    output data_t    rd_data1_o,
    output data_t    rd_data2_o,
    output logic     rd_ready1_o,
    output logic     rd_ready2_o,

    input  logic     wr_valid_i,
    input  reg_idx_t wr_rd_i,
    input  data_t    wr_data_i,
    input  tag_t     wr_tag_i,

    input  logic     alloc_i,
    input  reg_idx_t alloc_rd_i,
    input  tag_t     alloc_tag_i
);

    data_t data_q [REG_COUNT];
    tag_t  tag_q  [REG_COUNT];
    logic  busy_q [REG_COUNT];

    logic wr_hit;
    logic alloc_hit;

    // a writeback lands only if it belongs to the latest allocation
    assign wr_hit = wr_valid_i
                 && (wr_rd_i != '0)
                 && busy_q[wr_rd_i]
                 && (tag_q[wr_rd_i] == wr_tag_i);

    // register 0 is never claimed
    assign alloc_hit = alloc_i && (alloc_rd_i != '0);

    assign rd_data1_o = (rd_addr1_i == '0) ? '0 : data_q[rd_addr1_i];
    assign rd_data2_o = (rd_addr2_i == '0) ? '0 : data_q[rd_addr2_i];

    assign rd_ready1_o = !busy_q[rd_addr1_i];
    assign rd_ready2_o = !busy_q[rd_addr2_i];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                data_q[i] <= '0;
                tag_q[i]  <= '0;
                busy_q[i] <= 1'b0;
            end
        end else begin
            if (wr_hit) begin
                data_q[wr_rd_i] <= wr_data_i;
                busy_q[wr_rd_i] <= 1'b0;
            end

            // allocation overrides a same-cycle writeback
            if (alloc_hit) begin
                busy_q[alloc_rd_i] <= 1'b1;
                tag_q[alloc_rd_i]  <= alloc_tag_i;
            end
        end
    end

endmodule

// File: hw/reg_read_stage.sv
`timescale 1ns/1ns

module reg_read_stage import core_cfg_pkg::*; import uop_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,

    input  logic     uop_valid_i,
    input  opcode_e  uop_op_i,
    input  reg_idx_t uop_rs1_i,
    input  logic     uop_rs1_en_i,
    input  reg_idx_t uop_rs2_i,
    input  logic     uop_rs2_en_i,
    input  reg_idx_t uop_rd_i,
    input  logic     uop_rd_alloc_i,
    input  imm_t     uop_imm_i,
    input  tag_t     uop_tag_i,

    output logic     stall_o,

    output reg_idx_t rf_addr1_o,
    output reg_idx_t rf_addr2_o,
    input  data_t    rf_data1_i,
    input  data_t    rf_data2_i,
    input  logic     rf_ready1_i,
    input  logic     rf_ready2_i,
    output logic     rf_alloc_o,
    output reg_idx_t rf_alloc_rd_o,
    output tag_t     rf_alloc_tag_o,

    output logic     ex_valid_o,
    output opcode_e  ex_op_o,
    output data_t    ex_a_o,
    output data_t    ex_b_o,
    output reg_idx_t ex_rd_o,
    output tag_t     ex_tag_o
);

    logic  src_wait;
    logic  accept;
    data_t opnd_a;
    data_t opnd_b;

    assign rf_addr1_o = uop_rs1_i;
    assign rf_addr2_o = uop_rs2_i;

    // any enabled source still pending
    assign src_wait = (uop_rs1_en_i && !rf_ready1_i) || (uop_rs2_en_i && !rf_ready2_i);
    assign stall_o  = uop_valid_i && src_wait;
    assign accept   = uop_valid_i && !src_wait;

    assign rf_alloc_o     = accept && uop_rd_alloc_i;
    assign rf_alloc_rd_o  = uop_rd_i;
    assign rf_alloc_tag_o = uop_tag_i;

    // unused sources read as zero
    assign opnd_a = uop_rs1_en_i ? rf_data1_i : '0;
    assign opnd_b = op_uses_imm(uop_op_i) ? uop_imm_i
                  : (uop_rs2_en_i ? rf_data2_i : '0);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            ex_op_o  <= uop_op_i;
            ex_a_o   <= opnd_a;
            ex_b_o   <= opnd_b;
            ex_rd_o  <= uop_rd_i;
            ex_tag_o <= uop_tag_i;
        end
    end

endmodule

// File: hw/exec_unit.sv
`timescale 1ns/1ns

module exec_unit import core_cfg_pkg::*; import uop_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,

    input  logic     ex_valid_i,
    input  opcode_e  ex_op_i,
    input  data_t    ex_a_i,
    input  data_t    ex_b_i,
    input  reg_idx_t ex_rd_i,
    input  tag_t     ex_tag_i,

    output logic     wb_valid_o,
    output reg_idx_t wb_rd_o,
    output data_t    wb_data_o,
    output tag_t     wb_tag_o
);

    data_t result;

    always_comb begin
        case (ex_op_i)
            OP_ADD,
            OP_ADDI: begin
                result = ex_a_i + ex_b_i;
            end
            OP_SUB: begin
                result = ex_a_i - ex_b_i;
            end
            OP_AND: begin
                result = ex_a_i & ex_b_i;
            end
            OP_OR: begin
                result = ex_a_i | ex_b_i;
            end
            OP_XOR: begin
                result = ex_a_i ^ ex_b_i;
            end
            // upper immediate already placed by the read stage
            OP_LUI: begin
                result = ex_b_i;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= ex_valid_i;
        end
    end

    // result register, held for one cycle as the writeback
    always_ff @(posedge clk_i) begin
        if (ex_valid_i) begin
            wb_rd_o   <= ex_rd_i;
            wb_data_o <= result;
            wb_tag_o  <= ex_tag_i;
        end
    end

endmodule

// File: hw/issue_core_top.sv
`timescale 1ns/1ns

module issue_core_top import core_cfg_pkg::*; import uop_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,

    input  logic     uop_valid_i,
    input  opcode_e  uop_op_i,
    input  reg_idx_t uop_rs1_i,
    input  logic     uop_rs1_en_i,
    input  reg_idx_t uop_rs2_i,
    input  logic     uop_rs2_en_i,
    input  reg_idx_t uop_rd_i,
    input  logic     uop_rd_alloc_i,
    input  imm_t     uop_imm_i,
    input  tag_t     uop_tag_i,

    output logic     stall_o,

    output logic     wb_valid_o,
    output reg_idx_t wb_rd_o,
    output data_t    wb_data_o,
    output tag_t     wb_tag_o
);

    reg_idx_t rf_addr1;
    reg_idx_t rf_addr2;
    data_t    rf_data1;
    data_t    rf_data2;
    logic     rf_ready1;
    logic     rf_ready2;
    logic     rf_alloc;
    reg_idx_t rf_alloc_rd;
    tag_t     rf_alloc_tag;

    logic     ex_valid;
    opcode_e  ex_op;
    data_t    ex_a;
    data_t    ex_b;
    reg_idx_t ex_rd;
    tag_t     ex_tag;

    reg_read_stage u_read (
        .clk_i          ( clk_i          ),
        .rstn_i         ( rstn_i         ),
        .uop_valid_i    ( uop_valid_i    ),
        .uop_op_i       ( uop_op_i       ),
        .uop_rs1_i      ( uop_rs1_i      ),
        .uop_rs1_en_i   ( uop_rs1_en_i   ),
        .uop_rs2_i      ( uop_rs2_i      ),
        .uop_rs2_en_i   ( uop_rs2_en_i   ),
        .uop_rd_i       ( uop_rd_i       ),
        .uop_rd_alloc_i ( uop_rd_alloc_i ),
        .uop_imm_i      ( uop_imm_i      ),
        .uop_tag_i      ( uop_tag_i      ),
        .stall_o        ( stall_o        ),
        .rf_addr1_o     ( rf_addr1       ),
        .rf_addr2_o     ( rf_addr2       ),
        .rf_data1_i     ( rf_data1       ),
        .rf_data2_i     ( rf_data2       ),
        .rf_ready1_i    ( rf_ready1      ),
        .rf_ready2_i    ( rf_ready2      ),
        .rf_alloc_o     ( rf_alloc       ),
        .rf_alloc_rd_o  ( rf_alloc_rd    ),
        .rf_alloc_tag_o ( rf_alloc_tag   ),
        .ex_valid_o     ( ex_valid       ),
        .ex_op_o        ( ex_op          ),
        .ex_a_o         ( ex_a           ),
        .ex_b_o         ( ex_b           ),
        .ex_rd_o        ( ex_rd          ),
        .ex_tag_o       ( ex_tag         )
    );

    // writeback goes straight back into the write port
    tagged_regfile u_rf (
        .clk_i       ( clk_i        ),
        .rstn_i      ( rstn_i       ),
        .rd_addr1_i  ( rf_addr1     ),
        .rd_addr2_i  ( rf_addr2     ),
        .rd_data1_o  ( rf_data1     ),
        .rd_data2_o  ( rf_data2     ),
        .rd_ready1_o ( rf_ready1    ),
        .rd_ready2_o ( rf_ready2    ),
        .wr_valid_i  ( wb_valid_o   ),
        .wr_rd_i     ( wb_rd_o      ),
        .wr_data_i   ( wb_data_o    ),
        .wr_tag_i    ( wb_tag_o     ),
        .alloc_i     ( rf_alloc     ),
        .alloc_rd_i  ( rf_alloc_rd  ),
        .alloc_tag_i ( rf_alloc_tag )
    );

    exec_unit u_exec (
        .clk_i      ( clk_i      ),
        .rstn_i     ( rstn_i     ),
        .ex_valid_i ( ex_valid   ),
        .ex_op_i    ( ex_op      ),
        .ex_a_i     ( ex_a       ),
        .ex_b_i     ( ex_b       ),
        .ex_rd_i    ( ex_rd      ),
        .ex_tag_i   ( ex_tag     ),
        .wb_valid_o ( wb_valid_o ),
        .wb_rd_o    ( wb_rd_o    ),
        .wb_data_o  ( wb_data_o  ),
        .wb_tag_o   ( wb_tag_o   )
    );

endmodule

// File: verif/tb_issue_core_cases.svh
// op, rs1, rs1_en, rs2, rs2_en, rd, rd_alloc, imm, tag,
// expected wb_rd, expected wb_data, stall expected, random imm with data from the model

// fresh register reads 0 then independent ops issue back to back
add_row(OP_ADD,  7, 1,  0, 1,  8, 1, 32'h0000_0000,  1,  8, 32'h0000_0000, 0, 0);
add_row(OP_LUI,  0, 0,  0, 0,  1, 1, 32'h1234_5000,  2,  1, 32'h1234_5000, 0, 0);
add_row(OP_ADDI, 0, 1,  0, 0,  2, 1, 32'h0000_0a5c,  3,  2, 32'h0000_0a5c, 0, 0);
add_row(OP_LUI,  0, 0,  0, 0,  3, 1, 32'h0f0f_0000,  4,  3, 32'h0f0f_0000, 0, 0);
// each reads the rd of the row before
add_row(OP_ADD,  3, 1,  1, 1,  4, 1, 32'h0000_0000,  5,  4, 32'h2143_5000, 1, 0);
add_row(OP_SUB,  4, 1,  2, 1,  5, 1, 32'h0000_0000,  6,  5, 32'h2143_45a4, 1, 0);
add_row(OP_AND,  5, 1,  3, 1,  6, 1, 32'h0000_0000,  7,  6, 32'h0103_0000, 1, 0);
add_row(OP_OR,   1, 1,  2, 1,  7, 1, 32'h0000_0000,  8,  7, 32'h1234_5a5c, 0, 0);
add_row(OP_XOR,  7, 1,  3, 1,  9, 1, 32'h0000_0000,  9,  9, 32'h1d3b_5a5c, 1, 0);
// r0 keeps 0 and is never busy
add_row(OP_LUI,  0, 0,  0, 0,  0, 1, 32'hdead_b000, 10,  0, 32'hdead_b000, 0, 0);
add_row(OP_ADD,  0, 1,  0, 1, 10, 1, 32'h0000_0000, 11, 10, 32'h0000_0000, 0, 0);
// second write to r11 retags it so the first writeback is dropped
add_row(OP_LUI,  0, 0,  0, 0, 11, 1, 32'h1111_0000, 12, 11, 32'h1111_0000, 0, 0);
add_row(OP_LUI,  0, 0,  0, 0, 11, 1, 32'h2222_0000, 13, 11, 32'h2222_0000, 0, 0);
add_row(OP_ADDI, 11, 1, 0, 0, 12, 1, 32'h0000_0005, 14, 12, 32'h2222_0005, 1, 0);
// r0 still reads 0 once the write to it has gone by
add_row(OP_OR,   0, 1,  0, 1, 16, 1, 32'h0000_0000,  2, 16, 32'h0000_0000, 0, 0);
// filler
add_row(OP_LUI,  0, 0,  0, 0, 13, 1, 32'h0000_0000, 15, 13, 32'h0000_0000, 0, 1);
add_row(OP_LUI,  0, 0,  0, 0, 14, 1, 32'h0000_0000,  0, 14, 32'h0000_0000, 0, 1);
add_row(OP_ADD, 13, 1, 14, 1, 15, 1, 32'h0000_0000,  1, 15, 32'h0000_0000, 1, 1);

// File: verif/tb_issue_core.sv
`timescale 1ns/1ns

module tb_issue_core import core_cfg_pkg::*; import uop_pkg::*; ();

    typedef struct packed {
        opcode_e  op;
        reg_idx_t rs1;
        logic     rs1_en;
        reg_idx_t rs2;
        logic     rs2_en;
        reg_idx_t rd;
        logic     rd_alloc;
        imm_t     imm;
        tag_t     tag;
        reg_idx_t exp_rd;
        data_t    exp_data;
        logic     exp_stall;
        logic     rnd;
    } row_t;

    typedef struct packed {
        int       row;
        int       due;
        reg_idx_t rd;
        data_t    data;
        tag_t     tag;
    } wb_exp_t;

    logic     clk_i = 1'b0;
    logic     rstn_i;
    logic     uop_valid_i;
    opcode_e  uop_op_i;
    reg_idx_t uop_rs1_i;
    logic     uop_rs1_en_i;
    reg_idx_t uop_rs2_i;
    logic     uop_rs2_en_i;
    reg_idx_t uop_rd_i;
    logic     uop_rd_alloc_i;
    imm_t     uop_imm_i;
    tag_t     uop_tag_i;
    logic     stall_o;
    logic     wb_valid_o;
    reg_idx_t wb_rd_o;
    data_t    wb_data_o;
    tag_t     wb_tag_o;

    row_t    rows [$];
    wb_exp_t exp_q [$];
    data_t   model [REG_COUNT] = '{default: '0};
    int      row_err [64];
    integer  seed;
    int      cycle = 0;
    int      err_cnt = 0;
    int      pass_rows = 0;
    int      fail_rows = 0;
    logic    hung = 1'b0;

    issue_core_top DUT (.*);

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) cycle <= cycle + 1;

    task automatic add_row(input opcode_e op, input int rs1, input int en1, input int rs2,
                           input int en2, input int rd, input int alloc, input imm_t imm,
                           input int tag, input int exp_rd, input data_t exp_data,
                           input int exp_stall, input int rnd);
        rows.push_back(row_t'{op, reg_idx_t'(rs1), en1 != 0, reg_idx_t'(rs2), en2 != 0,
                              reg_idx_t'(rd), alloc != 0, imm, tag_t'(tag),
                              reg_idx_t'(exp_rd), exp_data, exp_stall != 0, rnd != 0});
    endtask

    task automatic load_cases();
        `include "tb_issue_core_cases.svh"
    endtask

    // ALU behavior as seen by the architecture
    function automatic data_t alu_ref(opcode_e op, data_t a, data_t b);
        case (op)
            OP_ADD, OP_ADDI: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_OR: return a | b;
            OP_XOR: return a ^ b;
            OP_LUI: return b;
            default: return '0;
        endcase
    endfunction

    task automatic note_error(int row);
        if (row >= 0) begin
            row_err[row]++;
        end
        err_cnt++;
    endtask

    task automatic check_data(string name, data_t exp, data_t act, int row);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            note_error(row);
        end
    endtask

    task automatic check_reg(string name, reg_idx_t exp, reg_idx_t act, int row);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            note_error(row);
        end
    endtask

    task automatic check_tag(string name, tag_t exp, tag_t act, int row);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            note_error(row);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act, int row);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            note_error(row);
        end
    endtask

    task automatic run_rows();
        row_t  r;
        data_t a;
        data_t b;
        data_t ref_val;
        int    stalls;
        int    accept;
        int    last_accept;
        last_accept = -10;
        @(posedge clk_i);
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (r.rnd) begin
                r.imm = $random(seed);
            end
            uop_valid_i    <= 1'b1;
            uop_op_i       <= r.op;
            uop_rs1_i      <= r.rs1;
            uop_rs1_en_i   <= r.rs1_en;
            uop_rs2_i      <= r.rs2;
            uop_rs2_en_i   <= r.rs2_en;
            uop_rd_i       <= r.rd;
            uop_rd_alloc_i <= r.rd_alloc;
            uop_imm_i      <= r.imm;
            uop_tag_i      <= r.tag;
            stalls = 0;
            @(negedge clk_i);
            while (stall_o === 1'b1 && stalls < 8) begin
                stalls++;
                @(negedge clk_i);
            end
            if (stall_o !== 1'b0) begin
                $display("row %0d: the stall never cleared within 8 cycles", i);
                note_error(i);
                hung = 1'b1;
                break;
            end
            accept = cycle + 1;
            check_flag("stall_o seen", r.exp_stall, stalls > 0, i);
            if (r.exp_stall && accept - last_accept < 3) begin
                $display("row %0d: accepted %0d cycles after its producer, at least 3 expected",
                         i, accept - last_accept);
                note_error(i);
            end
            // architectural sources, in program order
            a = r.rs1_en ? model[r.rs1] : '0;
            b = (r.op == OP_ADDI || r.op == OP_LUI) ? r.imm : (r.rs2_en ? model[r.rs2] : '0);
            ref_val = alu_ref(r.op, a, b);
            if (!r.rnd) begin
                check_data("table wb_data vs model", r.exp_data, ref_val, i);
            end
            exp_q.push_back(wb_exp_t'{i, accept + 1, r.exp_rd,
                                      r.rnd ? ref_val : r.exp_data, r.tag});
            if (r.rd_alloc && r.rd != '0) begin
                model[r.rd] = ref_val;
            end
            @(posedge clk_i);
            last_accept = accept;
        end
        uop_valid_i <= 1'b0;
    endtask

    always @(negedge clk_i) begin : wb_monitor
        wb_exp_t e;
        if (rstn_i === 1'b1 && wb_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("writeback at %0t with no micro-op outstanding", $time);
                note_error(-1);
            end else begin
                e = exp_q.pop_front();
                if (cycle != e.due) begin
                    $display("row %0d: writeback in cycle %0d, expected in cycle %0d",
                             e.row, cycle, e.due);
                    note_error(e.row);
                end
                check_reg("wb_rd_o", e.rd, wb_rd_o, e.row);
                check_data("wb_data_o", e.data, wb_data_o, e.row);
                check_tag("wb_tag_o", e.tag, wb_tag_o, e.row);
                if (row_err[e.row] == 0) begin
                    pass_rows++;
                end else begin
                    fail_rows++;
                end
                $display("row %0d rd %0d: %s", e.row, e.rd, row_err[e.row] == 0 ? "ok" : "errors");
            end
        end
    end

    initial begin
        seed           = 32'h64f9_b301;
        rstn_i         = 1'b0;
        uop_valid_i    = 1'b0;
        uop_op_i       = OP_ADD;
        uop_rs1_i      = '0;
        uop_rs1_en_i   = 1'b0;
        uop_rs2_i      = '0;
        uop_rs2_en_i   = 1'b0;
        uop_rd_i       = '0;
        uop_rd_alloc_i = 1'b0;
        uop_imm_i      = '0;
        uop_tag_i      = '0;
        load_cases();
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        check_flag("stall_o", 1'b0, stall_o, -1);
        check_flag("wb_valid_o", 1'b0, wb_valid_o, -1);
        run_rows();
        while (!hung && exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (2) @(negedge clk_i);
        $display("rows passed: %0d, rows failed: %0d", pass_rows, fail_rows);
        if (err_cnt == 0 && !hung && pass_rows == rows.size()) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // worst case is every row stalling to its limit
    initial begin
        wait (rows.size() > 0);
        repeat (rows.size() * 12 + 50) @(posedge clk_i);
        $display("watchdog: run did not complete within %0d cycles", rows.size() * 12 + 50);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: sim.f
+incdir+verif
hw/core_cfg_pkg.sv
hw/uop_pkg.sv
hw/tagged_regfile.sv
hw/reg_read_stage.sv
hw/exec_unit.sv
hw/issue_core_top.sv
verif/tb_issue_core.sv

// File: Bender.yml
package:
  name: issue_core

sources:
  - hw/core_cfg_pkg.sv
  - hw/uop_pkg.sv
  - hw/tagged_regfile.sv
  - hw/reg_read_stage.sv
  - hw/exec_unit.sv
  - hw/issue_core_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_issue_core.sv
